//--- filelist.f
+incdir+include
hw/cart_pkg.sv
hw/cart_hdr_parser.sv
hw/region_select.sv
hw/rom_write_port.sv
hw/cart_loader_top.sv
tb/cart_loader_chk.sv
tb/tb_cart_loader.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_cart_loader
FILELIST  := filelist.f
SRCS      := $(shell grep -v '^+' $(FILELIST)) include/cart_consts.svh
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean
all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_cart_loader.sv
/*
 * Testbench for the cartridge loader front end.
 * Streams one synthetic ROM per table row, models both ROM memories
 * with random ack delays and checks header, region and write results.
 */
`timescale 1ns/100ps

`include "cart_consts.svh"

module tb_cart_loader import cart_pkg::*; ();

	typedef struct {
		logic [63:0] id;
		logic [15:0] r0;       // Both region bytes at the first address
		logic [7:0]  r1;
		logic [2:0]  jue;      // Expected {j, u, e}
		auto_region_e mode;
		region_prio_e prio;
		logic [7:0]  idx;
		logic [7:0]  quirks;   // {sram .. schan}
		logic        gtype;
		logic [7:0]  gdly;
		region_e     region;
		logic        set;
	} row_t;

	localparam int NUM_ROWS = 13;
	localparam int WORDS    = 'h210 / 2;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * WORDS * 12 + 100;

	logic clk_sys = 1'b0, RESET = 1'b1, dl_active = 1'b0;
	dl_wr_t dl = '0;
	logic [7:0] dl_index = '0;
	region_cfg_t cfg = '0;
	logic [1:0] mem_ack = '0;
	hdr_info_t hdr;
	logic hdr_ready, region_set, rom_wr_req, dl_wait;
	region_e region_req;
	logic [23:0] rom_addr;
	logic [15:0] rom_data, sent_data;
	logic [24:0] rom_size, sent_addr;
	logic [15:0] lfsr_state = 16'd23090;
	int errors = 0;
	int mem_writes = 0;
	row_t rows [NUM_ROWS];

	always #4 clk_sys = ~clk_sys;

	cart_loader_top u_cart_loader_top (.clk_sys, .RESET, .dl, .dl_active, .dl_index, .cfg,
		.mem_ack_a(mem_ack[0]), .mem_ack_b(mem_ack[1]), .hdr, .hdr_ready, .region_req,
		.region_set, .rom_wr_req, .rom_addr, .rom_data, .dl_wait, .rom_size);

	bind cart_loader_top cart_loader_chk u_chk (.*);

	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	// Draw n bits, one LFSR step each
	function automatic int lfsr_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_step());
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Header fields at their addresses, address pattern elsewhere
	function automatic logic [15:0] rom_word(input row_t r, input logic [24:0] a);
		case (a)
			`CART_ADDR_ID0:     return {a[8:1] ^ 8'h5A, r.id[63:56]};
			`CART_ADDR_ID1:     return r.id[55:40];
			`CART_ADDR_ID2:     return r.id[39:24];
			`CART_ADDR_ID3:     return r.id[23:8];
			`CART_ADDR_ID4:     return {r.id[7:0], 8'hC3};
			`CART_ADDR_REGION0: return r.r0;
			`CART_ADDR_REGION1: return {8'h20, r.r1};
			default:            return a[15:0] ^ 16'(a[24:16]) ^ 16'h3C5A;
		endcase
	endfunction

	task automatic ack_after(input int m, input int dly, input logic val);
		repeat (dly) @(posedge clk_sys);
		#1 mem_ack[m] = val;
	endtask

	// Both memories take the request on the same edge, each answers late
	task automatic run_memories();
		logic seen;
		int dly_a;
		int dly_b;
		seen = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (!RESET && rom_wr_req !== seen) begin
				seen = rom_wr_req;
				check_value("rom_addr", rom_addr, sent_addr[24:1]);
				check_value("rom_data", rom_data, {sent_data[7:0], sent_data[15:8]});
				mem_writes++;
				dly_a = lfsr_bits(3);
				dly_b = lfsr_bits(3);
				fork
					ack_after(0, dly_a, seen);
					ack_after(1, dly_b, seen);
				join
			end
		end
	endtask

	initial run_memories();

	initial begin
		#(TIMEOUT_CYCLES * 8);
		$display("Timeout, the download did not finish in %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	task automatic run_row(input int n, input row_t r);
		@(posedge clk_sys) #1;
		cfg.auto_region = r.mode;
		cfg.prio = r.prio;
		dl_index = r.idx;
		dl_active = 1'b1;
		mem_writes = 0;
		@(posedge clk_sys) #1;
		for (int a = 0; a < 'h210; a += 2) begin
			sent_addr = 25'(a);
			sent_data = rom_word(r, 25'(a));
			dl = '{wr: 1'b1, addr: sent_addr, data: sent_data};
			@(posedge clk_sys) #1;
			dl.wr = 1'b0;
			while (dl_wait)
				@(posedge clk_sys) #1;
		end
		check_value("hdr.quirks", hdr.quirks, r.quirks);
		check_value("hdr.gun_type", hdr.gun_type, r.gtype);
		check_value("hdr.gun_delay", hdr.gun_delay, r.gdly);
		check_value("{hdr_j, hdr_u, hdr_e}", {hdr.hdr_j, hdr.hdr_u, hdr.hdr_e}, r.jue);
		check_value("hdr_ready", hdr_ready, 1'b1);
		check_value("region_set", region_set, r.set);
		check_value("region_req", region_req, r.region);
		check_value("mem_writes", mem_writes, WORDS);
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
		check_value("rom_size", rom_size, 25'h20E);
		check_value("hdr_ready", hdr_ready, 1'b0);
		$display("Row %0d done, %0d errors so far", n, errors);
	endtask

	initial begin
		rows[0]  = '{`CART_ID_SRAM0, "JU", " ", 3'b110, FROM_HEADER, US_EU_JP, 0,
			8'h80, 0, 44, REGION_US, 1};
		rows[1]  = '{`CART_ID_EEPROM0, "E ", " ", 3'b001, FROM_HEADER, EU_US_JP, 0,
			8'h40, 0, 44, REGION_EU, 1};
		rows[2]  = '{`CART_ID_NORAM0, "J ", "E", 3'b101, FROM_HEADER, US_JP_EU, 0,
			8'h20, 0, 44, REGION_JP, 1};
		rows[3]  = '{`CART_ID_FIFO0, "  ", " ", 3'b000, FROM_HEADER, JP_US_EU, 0,
			8'h10, 0, 44, REGION_JP, 1};
		rows[4]  = '{`CART_ID_PIER0, "U ", " ", 3'b010, FROM_HEADER, JP_US_EU, 0,
			8'h08, 0, 44, REGION_US, 1};
		rows[5]  = '{`CART_ID_SVP0, "J ", " ", 3'b100, FROM_FILE_EXT, US_EU_JP, 8'h80,
			8'h04, 0, 44, REGION_EU, 1};
		rows[6]  = '{`CART_ID_FMBUSY0, "J ", " ", 3'b100, FROM_FILE_EXT, US_EU_JP, 0,
			8'h02, 0, 44, REGION_JP, 0};
		// Selection off, region keeps the previous row's value
		rows[7]  = '{`CART_ID_SCHAN0, "J ", " ", 3'b100, DISABLED, US_EU_JP, 8'h40,
			8'h01, 0, 44, REGION_JP, 0};
		rows[8]  = '{`CART_GUN_ID0, "  ", " ", 3'b000, FROM_HEADER, US_EU_JP, 0,
			0, 0, 100, REGION_US, 1};
		rows[9]  = '{`CART_GUN_ID1, "JU", " ", 3'b110, FROM_HEADER, EU_US_JP, 0,
			0, 1, 52, REGION_US, 1};
		rows[10] = '{`CART_GUN_ID2, "  ", "E", 3'b001, FROM_HEADER, US_JP_EU, 0,
			0, 1, 30, REGION_EU, 1};
		rows[11] = '{`CART_GUN_ID3, "UE", " ", 3'b011, FROM_HEADER, JP_US_EU, 0,
			0, 0, 120, REGION_US, 1};
		rows[12] = '{`CART_GUN_ID4, "J ", "U", 3'b110, FROM_HEADER, EU_US_JP, 0,
			0, 0, 126, REGION_US, 1};
		repeat (10) @(posedge clk_sys);
		#1 RESET = 1'b0;
		check_value("dl_wait", dl_wait, 1'b0);
		check_value("rom_wr_req", rom_wr_req, 1'b0);
		check_value("region_set", region_set, 1'b0);
		check_value("hdr_ready", hdr_ready, 1'b0);
		check_value("hdr.quirks", hdr.quirks, 8'h00);
		check_value("hdr.gun_delay", hdr.gun_delay, `CART_GUN_DELAY_DEFAULT);
		for (int n = 0; n < NUM_ROWS; n++)
			run_row(n, rows[n]);
		errors += u_cart_loader_top.u_chk.fails;
		$display("%0d rows run, %0d errors", NUM_ROWS, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- tb/cart_loader_chk.sv
/*
 * Protocol checks for the cartridge loader, bound into the DUT top.
 * Covers the write handshake and the region timing.
 */
`timescale 1ns/100ps

module cart_loader_chk import cart_pkg::*; (
	input logic   clk_sys,
	input logic   RESET,
	input dl_wr_t dl,
	input logic   dl_active,
	input logic   dl_wait,
	input logic   rom_wr_req,
	input logic   hdr_ready,
	input logic   region_set
);

	logic ready_d;   // hdr_ready one cycle late
	int   fails = 0; // Failed assertion count

	always_ff @(posedge clk_sys)
		ready_d <= hdr_ready;

	// Source must hold off while the memories are busy
	no_write_while_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		!(dl.wr && dl_active && dl_wait))
		else begin
			$error("write issued while dl_wait high");
			fails++;
		end

	req_toggle_needs_write: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(rom_wr_req) |-> $past(dl.wr && dl_active))
		else begin
			$error("rom_wr_req toggled without a write");
			fails++;
		end

	region_set_after_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(region_set) |-> $past(hdr_ready && !ready_d))
		else begin
			$error("region_set rose outside the hdr_ready edge");
			fails++;
		end

endmodule

//--- hw/cart_loader_top.sv
/*
 * Cartridge loader front end.
 * Connects the header parser, the region selector and the ROM write
 * port to the download stream and the two ROM memories.
 */
`timescale 1ns/100ps

module cart_loader_top import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  dl_wr_t      dl,
	input  logic        dl_active,
	input  logic [7:0]  dl_index,
	input  region_cfg_t cfg,
	input  logic        mem_ack_a,
	input  logic        mem_ack_b,
	output hdr_info_t   hdr,
	output logic        hdr_ready,
	output region_e     region_req,
	output logic        region_set,
	output logic        rom_wr_req,
	output logic [23:0] rom_addr,
	output logic [15:0] rom_data,
	output logic        dl_wait,
	output logic [24:0] rom_size
);

	// Header record producer
	cart_hdr_parser u_hdr_parser (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl        (dl),
		.dl_active (dl_active),
		.hdr       (hdr),
		.hdr_ready (hdr_ready)
	);

	region_select u_region_select (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.hdr        (hdr),
		.hdr_ready  (hdr_ready),
		.dl_index   (dl_index),
		.cfg        (cfg),
		.region_req (region_req),
		.region_set (region_set)
	);

	rom_write_port u_rom_write_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.dl_active  (dl_active),
		.mem_ack_a  (mem_ack_a),
		.mem_ack_b  (mem_ack_b),
		.rom_wr_req (rom_wr_req),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.dl_wait    (dl_wait),
		.rom_size   (rom_size)
	);

endmodule

//--- hw/rom_write_port.sv
/*
 * ROM write port.
 * Buffers one download word, forwards it to both ROM memories with a
 * toggle request and holds dl_wait until both have echoed it.
 * Latches the final address as the ROM size when the download ends.
 */
`timescale 1ns/100ps

module rom_write_port import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  dl_wr_t      dl,
	input  logic        dl_active,
	input  logic        mem_ack_a,
	input  logic        mem_ack_b,
	output logic        rom_wr_req,
	output logic [23:0] rom_addr,
	output logic [15:0] rom_data,
	output logic        dl_wait,
	output logic [24:0] rom_size
);

	logic [24:0] wr_addr;     // Byte address of the buffered word
	logic        old_active;
	logic        acks_done;

	assign rom_addr  = wr_addr[24:1];
	assign acks_done = (mem_ack_a == rom_wr_req) && (mem_ack_b == rom_wr_req);

	// Word buffer, memories take the bytes swapped
	always_ff @(posedge clk_sys) begin
		if (dl.wr & dl_active) begin
			wr_addr  <= dl.addr;
			rom_data <= {dl.data[7:0], dl.data[15:8]};
		end
		if (old_active & ~dl_active)
			rom_size <= wr_addr;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_active <= 1'b0;
			rom_wr_req <= 1'b0;
			dl_wait    <= 1'b0;
		end else begin
			old_active <= dl_active;

			if (dl.wr & dl_active) begin
				dl_wait    <= 1'b1;
				rom_wr_req <= ~rom_wr_req;      // New request to both memories
			end else if (dl_wait && acks_done) begin
				dl_wait    <= 1'b0;
			end
		end
	end

endmodule

//--- hw/region_select.sv
/*
 * Console region selection.
 * On the rising edge of hdr_ready picks a region from the header flags
 * in priority order, or from the file index, and requests it.
 */
`timescale 1ns/100ps

module region_select import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  hdr_info_t   hdr,
	input  logic        hdr_ready,
	input  logic [7:0]  dl_index,
	input  region_cfg_t cfg,
	output region_e     region_req,
	output logic        region_set
);

	logic old_ready;

	// First flagged region in the given order, else the order's head
	function automatic region_e pick_region(input region_prio_e prio,
	                                        input logic j, input logic u, input logic e);
		case (prio)
			US_EU_JP: return u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			EU_US_JP: return e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			US_JP_EU: return u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			default:  return j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready  <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr_ready;

			if (~old_ready & hdr_ready) begin
				case (cfg.auto_region)
					FROM_HEADER: begin
						region_set <= 1'b1;
						region_req <= pick_region(cfg.prio, hdr.hdr_j, hdr.hdr_u, hdr.hdr_e);
					end
					FROM_FILE_EXT: begin
						region_set <= |dl_index;          // Index 0 means no region
						region_req <= region_e'(dl_index[7:6]);
					end
					default: ;                            // Selection off
				endcase
			end

			if (old_ready & ~hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

//--- hw/cart_hdr_parser.sv
/*
 * ROM header parser.
 * Watches the download stream, assembles the product ID and reads the
 * region bytes. Produces the quirk flags, light-gun settings and region
 * flags, and raises hdr_ready once the header has gone past.
 */
`timescale 1ns/100ps

`include "cart_consts.svh"

module cart_hdr_parser import cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      RESET,
	input  dl_wr_t    dl,
	input  logic      dl_active,
	output hdr_info_t hdr,
	output logic      hdr_ready
);

	logic [63:0] cart_id;     // First character in the top byte
	logic        old_active;
	logic        wr_en;
	logic        dl_start;
	logic        dl_end;
	logic [2:0]  flags_lo;    // {j, u, e}
	logic [2:0]  flags_hi;

	// Classify one region character
	function automatic logic [2:0] region_flags(input logic [7:0] c);
		if (c == "J")
			return 3'b100;
		else if (c == "U")
			return 3'b010;
		else if (c >= "0" && c <= "Z")
			return 3'b001;
		else
			return 3'b000;
	endfunction

	assign wr_en    = dl.wr & dl_active;
	assign dl_start = ~old_active & dl_active;
	assign dl_end   = old_active & ~dl_active;
	assign flags_lo = region_flags(dl.data[7:0]);
	assign flags_hi = (dl.addr == `CART_ADDR_REGION0) ? region_flags(dl.data[15:8]) : 3'b000;

	//////////////////////////////////////////////////////////////////////
	// Product ID capture
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (dl.addr)
				`CART_ADDR_ID0: cart_id[63:56] <= dl.data[7:0];
				`CART_ADDR_ID1: cart_id[55:40] <= dl.data;
				`CART_ADDR_ID2: cart_id[39:24] <= dl.data;
				`CART_ADDR_ID3: cart_id[23:8]  <= dl.data;
				`CART_ADDR_ID4: cart_id[7:0]   <= dl.data[15:8];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Header record
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_active    <= 1'b0;
			hdr_ready     <= 1'b0;
			hdr.quirks    <= '0;
			hdr.gun_type  <= 1'b0;
			hdr.gun_delay <= `CART_GUN_DELAY_DEFAULT;
			{hdr.hdr_j, hdr.hdr_u, hdr.hdr_e} <= 3'b000;
		end else begin
			old_active <= dl_active;

			if (dl_start) begin
				hdr.quirks <= '0;
				{hdr.hdr_j, hdr.hdr_u, hdr.hdr_e} <= 3'b000;
			end
			if (dl_end)
				hdr_ready <= 1'b0;

			if (wr_en) begin
				if (dl.addr == `CART_ADDR_REGION0 || dl.addr == `CART_ADDR_REGION1)
					{hdr.hdr_j, hdr.hdr_u, hdr.hdr_e} <=
						{hdr.hdr_j, hdr.hdr_u, hdr.hdr_e} | flags_lo | flags_hi;

				if (dl.addr == `CART_ADDR_HDR_END)
					hdr_ready <= 1'b1;

				if (dl.addr == `CART_ADDR_ID_DONE) begin
					case (cart_id)
						`CART_ID_SRAM0, `CART_ID_SRAM1, `CART_ID_SRAM2,
						`CART_ID_SRAM3, `CART_ID_SRAM4:     hdr.quirks.sram <= 1'b1;
						`CART_ID_EEPROM0, `CART_ID_EEPROM1, `CART_ID_EEPROM2,
						`CART_ID_EEPROM3, `CART_ID_EEPROM4, `CART_ID_EEPROM5,
						`CART_ID_EEPROM6, `CART_ID_EEPROM7,
						`CART_ID_EEPROM8:                   hdr.quirks.eeprom <= 1'b1;
						`CART_ID_NORAM0:                    hdr.quirks.noram <= 1'b1;
						`CART_ID_FIFO0:                     hdr.quirks.fifo <= 1'b1;
						`CART_ID_PIER0, `CART_ID_PIER1:     hdr.quirks.pier <= 1'b1;
						`CART_ID_SVP0, `CART_ID_SVP1:       hdr.quirks.svp <= 1'b1;
						`CART_ID_FMBUSY0, `CART_ID_FMBUSY1,
						`CART_ID_FMBUSY2:                   hdr.quirks.fmbusy <= 1'b1;
						`CART_ID_SCHAN0:                    hdr.quirks.schan <= 1'b1;
						default: ;
					endcase

					// Gun sensor timing per title
					case (cart_id)
						`CART_GUN_ID0: {hdr.gun_type, hdr.gun_delay} <= {`CART_GUN_TYPE0, `CART_GUN_DLY0};
						`CART_GUN_ID1: {hdr.gun_type, hdr.gun_delay} <= {`CART_GUN_TYPE1, `CART_GUN_DLY1};
						`CART_GUN_ID2: {hdr.gun_type, hdr.gun_delay} <= {`CART_GUN_TYPE2, `CART_GUN_DLY2};
						`CART_GUN_ID3: {hdr.gun_type, hdr.gun_delay} <= {`CART_GUN_TYPE3, `CART_GUN_DLY3};
						`CART_GUN_ID4: {hdr.gun_type, hdr.gun_delay} <= {`CART_GUN_TYPE4, `CART_GUN_DLY4};
						default:       {hdr.gun_type, hdr.gun_delay} <= {1'b0, `CART_GUN_DELAY_DEFAULT};
					endcase
				end
			end
		end
	end

endmodule

//--- hw/cart_pkg.sv
/*
 * Types shared by the cartridge loader blocks and the testbench.
 * Region and setting enums, the download write record, the header
 * record and the region configuration. Import with cart_pkg::*.
 */
package cart_pkg;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// Where the console region comes from
	typedef enum logic [1:0] {
		FROM_FILE_EXT = 2'd0,
		FROM_HEADER   = 2'd1,
		DISABLED      = 2'd2
	} auto_region_e;

	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} region_prio_e;

	typedef struct packed {
		logic        wr;
		logic [24:0] addr;  // Byte address
		logic [15:0] data;  // High byte is the earlier character
	} dl_wr_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} cart_quirks_t;

	typedef struct packed {
		cart_quirks_t quirks;
		logic         gun_type;   // 1 for reload style guns
		logic [7:0]   gun_delay;
		logic         hdr_j;
		logic         hdr_u;
		logic         hdr_e;
	} hdr_info_t;

	typedef struct packed {
		auto_region_e auto_region;
		region_prio_e prio;
	} region_cfg_t;

endpackage

//--- include/cart_consts.svh
/*
 * Cartridge header constants for the loader front end.
 * Byte addresses of the header fields, the product IDs that need a
 * core quirk, and the light-gun table. Include wherever IDs are matched.
 */
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// Header word addresses, byte addressed
`define CART_ADDR_ID0      25'h182
`define CART_ADDR_ID1      25'h184
`define CART_ADDR_ID2      25'h186
`define CART_ADDR_ID3      25'h188
`define CART_ADDR_ID4      25'h18A
`define CART_ADDR_ID_DONE  25'h18C  // Lookup trigger
`define CART_ADDR_REGION0  25'h1F0
`define CART_ADDR_REGION1  25'h1F2
`define CART_ADDR_HDR_END  25'h200

// Quirk product IDs, 8 characters each
`define CART_ID_SRAM0    "T-081276"
`define CART_ID_SRAM1    "T-81406 "
`define CART_ID_SRAM2    "T-081586"
`define CART_ID_SRAM3    "T-81576 "
`define CART_ID_SRAM4    "T-81476 "
`define CART_ID_EEPROM0  "MK-1215 "
`define CART_ID_EEPROM1  "G-4060  "
`define CART_ID_EEPROM2  "00001211"
`define CART_ID_EEPROM3  "MK-1228 "
`define CART_ID_EEPROM4  "G-5538  "
`define CART_ID_EEPROM5  "00004076"
`define CART_ID_EEPROM6  "T-12046 "
`define CART_ID_EEPROM7  "T-12053 "
`define CART_ID_EEPROM8  "G-4524  "
`define CART_ID_NORAM0   "T-113016"
`define CART_ID_FIFO0    "T-89016 "
`define CART_ID_PIER0    "T-574023"
`define CART_ID_PIER1    "T-574013"
`define CART_ID_SVP0     "MK-1229 "
`define CART_ID_SVP1     "G-7001  "
`define CART_ID_FMBUSY0  "T-35036 "
`define CART_ID_FMBUSY1  "T-25073 "
`define CART_ID_FMBUSY2  "MK-1137-"
`define CART_ID_SCHAN0   "T-68???-"

// Light-gun titles, sensor delay and reload type
`define CART_GUN_ID0     "MK-1533 "
`define CART_GUN_DLY0    8'd100
`define CART_GUN_TYPE0   1'b0
`define CART_GUN_ID1     "T-95096-"
`define CART_GUN_DLY1    8'd52
`define CART_GUN_TYPE1   1'b1
`define CART_GUN_ID2     "T-95136-"
`define CART_GUN_DLY2    8'd30
`define CART_GUN_TYPE2   1'b1
`define CART_GUN_ID3     "MK-1658 "
`define CART_GUN_DLY3    8'd120
`define CART_GUN_TYPE3   1'b0
`define CART_GUN_ID4     "T-081156"
`define CART_GUN_DLY4    8'd126
`define CART_GUN_TYPE4   1'b0

`define CART_GUN_DELAY_DEFAULT  8'd44

`endif
